// File: Bender.yml
package:
  name: rib

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/rib_pkg.sv
      - common/rib_req_if.sv
      - rib/rib_arbiter.sv
      - rib/rib_master_mux.sv
      - rib/rib_slave_router.sv
      - rib/rib_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - tests/rib_slave_model.sv
      - tests/tb_rib_top.sv

// File: common/rib_pkg.sv
/*
 * Types shared by the bus interconnect.
 * The master id codes double as bit positions in the arbiter request vector.
 */
`include "rib_settings.svh"

package rib_pkg;

    // code 3 is never granted
    typedef enum logic [1:0] {
        MASTER_DATA  = 2'd0,  // m0, highest priority
        MASTER_FETCH = 2'd1,  // m1, parks the grant
        MASTER_AUX   = 2'd2   // m2
    } master_id_e;

    // select in the top bits, offset below
    typedef struct packed {
        logic [`RIB_SEL_W-1:0]    sel;
        logic [`RIB_OFFSET_W-1:0] offset;
    } rib_addr_fields_s;

    // mux passes the raw word, router splits it
    typedef union packed {
        logic [`RIB_ADDR_W-1:0] raw;
        rib_addr_fields_s       fields;
    } rib_addr_u;

endpackage

// File: common/rib_req_if.sv
/*
 * Carries the single granted request from the master mux to the slave router.
 * Response signals are combinational in the same cycle as the request.
 */
`include "rib_settings.svh"

interface rib_req_if;

    rib_pkg::rib_addr_u       addr;   // full address, select still in it
    logic [`RIB_DATA_W-1:0]   wdata;
    logic                     we;
    logic                     req;
    logic [`RIB_DATA_W-1:0]   rdata;  // from the selected slave
    logic                     ack;

    modport mux_mp (
        output addr,
        output wdata,
        output we,
        output req,
        input  rdata,
        input  ack
    );

    modport router_mp (
        input  addr,
        input  wdata,
        input  we,
        input  req,
        output rdata,
        output ack
    );

endinterface

// File: common/rib_settings.svh
/*
 * Bus widths, counts and the fetch default word.
 * The select field always sits at the top of the address, so SEL_W + OFFSET_W
 * must equal ADDR_W. Selects from N_SLAVES upward are unmapped.
 */
`ifndef RIB_SETTINGS_SVH
`define RIB_SETTINGS_SVH

// address and data path
`define RIB_ADDR_W      32
`define RIB_DATA_W      32

// top nibble picks the slave, the rest is the offset
`define RIB_SEL_W       4
`define RIB_OFFSET_W    28

// masters: data, fetch, aux
`define RIB_N_MASTERS   3

// selects 0..3 mapped
`define RIB_N_SLAVES    4

// addi x0, x0, 0
`define RIB_INST_NOP    32'h0000_0013

`endif

// File: list.f
+incdir+common
common/rib_pkg.sv
common/rib_req_if.sv
rib/rib_arbiter.sv
rib/rib_master_mux.sv
rib/rib_slave_router.sv
rib/rib_top.sv
tests/rib_slave_model.sv
tests/tb_rib_top.sv

// File: rib/rib_arbiter.sv
/*
 * Registered fixed-priority arbiter: m0 over m2 over m1.
 * A new requester is granted from the next cycle on; m1 holds the grant
 * whenever nobody else asks. hold_flag_o is combinational from the requests.
 */
`include "rib_settings.svh"

module rib_arbiter (
    input  logic                      clk,
    input  logic                      arst_n_i,
    input  logic [`RIB_N_MASTERS-1:0] req_i,       // bit index = master id
    output rib_pkg::master_id_e       grant_o,
    output logic                      hold_flag_o
);

    rib_pkg::master_id_e grant_q;
    rib_pkg::master_id_e grant_d;

    // priority pick for the next cycle
    always_comb begin
        if (req_i[rib_pkg::MASTER_DATA]) begin
            grant_d = rib_pkg::MASTER_DATA;
        end else if (req_i[rib_pkg::MASTER_AUX]) begin
            grant_d = rib_pkg::MASTER_AUX;
        end else begin
            grant_d = rib_pkg::MASTER_FETCH;    // park on fetch
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            grant_q <= rib_pkg::MASTER_FETCH;
        end else begin
            grant_q <= grant_d;
        end
    end

    assign grant_o = grant_q;

    // stall the pipeline while a non-parking master wants the bus
    assign hold_flag_o = req_i[rib_pkg::MASTER_DATA] | req_i[rib_pkg::MASTER_AUX];

    // the mux has no path for code 3, so a master would hang forever
    grant_code_legal_a: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        grant_o inside {rib_pkg::MASTER_DATA, rib_pkg::MASTER_FETCH, rib_pkg::MASTER_AUX}
    ) else $error("arbiter grant took unused code %0d", grant_o);

endmodule

// File: rib/rib_master_mux.sv
/*
 * Puts the granted master's request on the internal bus and hands the
 * response back to that master only. Data to a master that is not acked is
 * zero, or the NOP word for the fetch master.
 */
`include "rib_settings.svh"

module rib_master_mux (
    input  rib_pkg::master_id_e     grant_i,
    // m0, data master
    input  logic [`RIB_ADDR_W-1:0]  m0_addr_i,
    input  logic [`RIB_DATA_W-1:0]  m0_data_i,
    input  logic                    m0_we_i,
    input  logic                    m0_req_i,
    output logic [`RIB_DATA_W-1:0]  m0_data_o,
    output logic                    m0_ack_o,
    // m1, instruction fetch
    input  logic [`RIB_ADDR_W-1:0]  m1_addr_i,
    input  logic [`RIB_DATA_W-1:0]  m1_data_i,
    input  logic                    m1_we_i,
    input  logic                    m1_req_i,
    output logic [`RIB_DATA_W-1:0]  m1_data_o,
    output logic                    m1_ack_o,
    // m2, second master
    input  logic [`RIB_ADDR_W-1:0]  m2_addr_i,
    input  logic [`RIB_DATA_W-1:0]  m2_data_i,
    input  logic                    m2_we_i,
    input  logic                    m2_req_i,
    output logic [`RIB_DATA_W-1:0]  m2_data_o,
    output logic                    m2_ack_o,
    rib_req_if.mux_mp               bus_o
);

    logic m0_served;
    logic m1_served;
    logic m2_served;

    always_comb begin
        bus_o.addr.raw = '0;
        bus_o.wdata    = '0;
        bus_o.we       = 1'b0;
        bus_o.req      = 1'b0;
        case (grant_i)
            rib_pkg::MASTER_DATA: begin
                bus_o.addr.raw = m0_addr_i;
                bus_o.wdata    = m0_data_i;
                bus_o.we       = m0_we_i;
                bus_o.req      = m0_req_i;
            end
            rib_pkg::MASTER_FETCH: begin
                bus_o.addr.raw = m1_addr_i;
                bus_o.wdata    = m1_data_i;
                bus_o.we       = m1_we_i;
                bus_o.req      = m1_req_i;
            end
            rib_pkg::MASTER_AUX: begin
                bus_o.addr.raw = m2_addr_i;
                bus_o.wdata    = m2_data_i;
                bus_o.we       = m2_we_i;
                bus_o.req      = m2_req_i;
            end
            default: begin
                bus_o.req      = 1'b0;  // no owner, bus idle
            end
        endcase
    end

    // only the grant owner ever sees the slave ack
    assign m0_served = (grant_i == rib_pkg::MASTER_DATA) && bus_o.ack;
    assign m1_served = (grant_i == rib_pkg::MASTER_FETCH) && bus_o.ack;
    assign m2_served = (grant_i == rib_pkg::MASTER_AUX) && bus_o.ack;

    assign m0_ack_o  = m0_served;
    assign m1_ack_o  = m1_served;
    assign m2_ack_o  = m2_served;
    assign m0_data_o = m0_served ? bus_o.rdata : '0;
    assign m1_data_o = m1_served ? bus_o.rdata : `RIB_INST_NOP;  // fetch stalls on a NOP
    assign m2_data_o = m2_served ? bus_o.rdata : '0;

    always_comb begin
        one_master_ack_a: assert final ($onehot0({m2_ack_o, m1_ack_o, m0_ack_o}))
            else $error("more than one master acked");
    end

endmodule

// File: rib/rib_slave_router.sv
/*
 * Decodes the top address nibble and drives the one matching slave with the
 * offset, top nibble cleared. Unmapped selects raise no slave request and
 * get no ack, so the master waits until it withdraws.
 */
`include "rib_settings.svh"

module rib_slave_router (
    rib_req_if.router_mp            bus_i,
    output logic [`RIB_ADDR_W-1:0]  s0_addr_o,
    output logic [`RIB_DATA_W-1:0]  s0_data_o,
    output logic                    s0_we_o,
    output logic                    s0_req_o,
    input  logic [`RIB_DATA_W-1:0]  s0_data_i,
    input  logic                    s0_ack_i,
    output logic [`RIB_ADDR_W-1:0]  s1_addr_o,
    output logic [`RIB_DATA_W-1:0]  s1_data_o,
    output logic                    s1_we_o,
    output logic                    s1_req_o,
    input  logic [`RIB_DATA_W-1:0]  s1_data_i,
    input  logic                    s1_ack_i,
    output logic [`RIB_ADDR_W-1:0]  s2_addr_o,
    output logic [`RIB_DATA_W-1:0]  s2_data_o,
    output logic                    s2_we_o,
    output logic                    s2_req_o,
    input  logic [`RIB_DATA_W-1:0]  s2_data_i,
    input  logic                    s2_ack_i,
    output logic [`RIB_ADDR_W-1:0]  s3_addr_o,
    output logic [`RIB_DATA_W-1:0]  s3_data_o,
    output logic                    s3_we_o,
    output logic                    s3_req_o,
    input  logic [`RIB_DATA_W-1:0]  s3_data_i,
    input  logic                    s3_ack_i
);

    logic [`RIB_SEL_W-1:0]    sel;
    logic [`RIB_ADDR_W-1:0]   offset_word;
    logic [`RIB_N_SLAVES-1:0] hit;          // one-hot or zero when unmapped
    logic [`RIB_N_SLAVES-1:0] s_ack;
    logic [`RIB_DATA_W-1:0]   s_rdata [`RIB_N_SLAVES];

    assign sel         = bus_i.addr.fields.sel;
    assign offset_word = {{`RIB_SEL_W{1'b0}}, bus_i.addr.fields.offset};

    always_comb begin
        for (int i = 0; i < `RIB_N_SLAVES; i++) begin
            hit[i] = (int'(sel) == i);
        end
    end

    assign s0_req_o  = hit[0] & bus_i.req;
    assign s0_we_o   = hit[0] & bus_i.we;
    assign s0_addr_o = hit[0] ? offset_word : '0;
    assign s0_data_o = hit[0] ? bus_i.wdata : '0;
    assign s1_req_o  = hit[1] & bus_i.req;
    assign s1_we_o   = hit[1] & bus_i.we;
    assign s1_addr_o = hit[1] ? offset_word : '0;
    assign s1_data_o = hit[1] ? bus_i.wdata : '0;
    assign s2_req_o  = hit[2] & bus_i.req;
    assign s2_we_o   = hit[2] & bus_i.we;
    assign s2_addr_o = hit[2] ? offset_word : '0;
    assign s2_data_o = hit[2] ? bus_i.wdata : '0;
    assign s3_req_o  = hit[3] & bus_i.req;
    assign s3_we_o   = hit[3] & bus_i.we;
    assign s3_addr_o = hit[3] ? offset_word : '0;
    assign s3_data_o = hit[3] ? bus_i.wdata : '0;

    // response side, gathered for the select loop
    assign s_ack      = {s3_ack_i, s2_ack_i, s1_ack_i, s0_ack_i};
    assign s_rdata[0] = s0_data_i;
    assign s_rdata[1] = s1_data_i;
    assign s_rdata[2] = s2_data_i;
    assign s_rdata[3] = s3_data_i;

    always_comb begin
        bus_i.ack   = 1'b0;   // unmapped stays silent
        bus_i.rdata = '0;
        for (int i = 0; i < `RIB_N_SLAVES; i++) begin
            if (hit[i]) begin
                bus_i.ack   = s_ack[i];
                bus_i.rdata = s_rdata[i];
            end
        end
    end

    always_comb begin
        one_slave_req_a: assert final ($onehot0({s3_req_o, s2_req_o, s1_req_o, s0_req_o}))
            else $error("more than one slave request at select %0d", sel);
    end

endmodule

// File: rib/rib_top.sv
/*
 * Three masters, four slaves, one transfer at a time.
 * Master to slave request and slave to master response are combinational
 * once the grant is held; grant changes take effect one cycle after a request.
 */
`include "rib_settings.svh"

module rib_top (
    input  logic                    clk,
    input  logic                    arst_n_i,
    input  logic [`RIB_ADDR_W-1:0]  m0_addr_i,
    input  logic [`RIB_DATA_W-1:0]  m0_data_i,
    output logic [`RIB_DATA_W-1:0]  m0_data_o,
    input  logic                    m0_req_i,
    input  logic                    m0_we_i,
    output logic                    m0_ack_o,
    input  logic [`RIB_ADDR_W-1:0]  m1_addr_i,
    input  logic [`RIB_DATA_W-1:0]  m1_data_i,
    output logic [`RIB_DATA_W-1:0]  m1_data_o,
    input  logic                    m1_req_i,
    input  logic                    m1_we_i,
    output logic                    m1_ack_o,
    input  logic [`RIB_ADDR_W-1:0]  m2_addr_i,
    input  logic [`RIB_DATA_W-1:0]  m2_data_i,
    output logic [`RIB_DATA_W-1:0]  m2_data_o,
    input  logic                    m2_req_i,
    input  logic                    m2_we_i,
    output logic                    m2_ack_o,
    output logic [`RIB_ADDR_W-1:0]  s0_addr_o,
    output logic [`RIB_DATA_W-1:0]  s0_data_o,
    input  logic [`RIB_DATA_W-1:0]  s0_data_i,
    output logic                    s0_req_o,
    output logic                    s0_we_o,
    input  logic                    s0_ack_i,
    output logic [`RIB_ADDR_W-1:0]  s1_addr_o,
    output logic [`RIB_DATA_W-1:0]  s1_data_o,
    input  logic [`RIB_DATA_W-1:0]  s1_data_i,
    output logic                    s1_req_o,
    output logic                    s1_we_o,
    input  logic                    s1_ack_i,
    output logic [`RIB_ADDR_W-1:0]  s2_addr_o,
    output logic [`RIB_DATA_W-1:0]  s2_data_o,
    input  logic [`RIB_DATA_W-1:0]  s2_data_i,
    output logic                    s2_req_o,
    output logic                    s2_we_o,
    input  logic                    s2_ack_i,
    output logic [`RIB_ADDR_W-1:0]  s3_addr_o,
    output logic [`RIB_DATA_W-1:0]  s3_data_o,
    input  logic [`RIB_DATA_W-1:0]  s3_data_i,
    output logic                    s3_req_o,
    output logic                    s3_we_o,
    input  logic                    s3_ack_i,
    output logic                    hold_flag_o   // pipeline stall to the core
);

    rib_pkg::master_id_e grant;

    rib_req_if req_bus ();

    rib_arbiter u_arbiter (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .req_i       ({m2_req_i, m1_req_i, m0_req_i}),  // index = master id
        .grant_o     (grant),
        .hold_flag_o (hold_flag_o)
    );

    // master ports match by name
    rib_master_mux u_master_mux (
        .grant_i (grant),
        .bus_o   (req_bus),
        .*
    );

    // slave ports match by name
    rib_slave_router u_slave_router (
        .bus_i (req_bus),
        .*
    );

endmodule

// File: tests/rib_slave_model.sv
/*
 * Behavioral memory slave, 16 words indexed by offset bits 5:2.
 * Acks combinationally while req is high and writes at the rising edge.
 * Contents start from a fill pattern built from slave id and word index.
 */
`include "rib_settings.svh"

module rib_slave_model #(
    parameter int SLAVE_ID = 0
) (
    input  logic                    clk,
    input  logic [`RIB_ADDR_W-1:0]  addr_i,
    input  logic [`RIB_DATA_W-1:0]  data_i,
    input  logic                    we_i,
    input  logic                    req_i,
    output logic [`RIB_DATA_W-1:0]  data_o,
    output logic                    ack_o
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [`RIB_DATA_W-1:0] mem [16];

    initial begin
        for (int i = 0; i < 16; i++) begin
            mem[i] = 32'hC0DE_0000 | (SLAVE_ID << 8) | i;   // id and index both visible
        end
    end

    always @(posedge clk) begin
        if (req_i && we_i) begin
            mem[addr_i[5:2]] <= data_i;
        end
    end

    assign data_o = mem[addr_i[5:2]];
    assign ack_o  = req_i;                  // zero wait states

endmodule

// File: tests/tb_rib_top.sv
/*
 * Testbench for rib_top: drives three masters, models four memory slaves.
 * Inputs change 1 ns after the rising edge, outputs are sampled at 3 ns.
 */
`include "rib_settings.svh"

module tb_rib_top;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int ACCESS_TIMEOUT = 1000;   // cycles per access
    localparam int RAND_OPS       = 30;     // per master

    logic                   clk;
    logic                   arst_n_i;
    logic [`RIB_ADDR_W-1:0] m_addr  [`RIB_N_MASTERS];
    logic [`RIB_DATA_W-1:0] m_wdata [`RIB_N_MASTERS];
    logic                   m_we    [`RIB_N_MASTERS];
    logic                   m_req   [`RIB_N_MASTERS];
    wire  [`RIB_DATA_W-1:0] m_rdata [`RIB_N_MASTERS];
    wire                    m_ack   [`RIB_N_MASTERS];
    wire  [`RIB_ADDR_W-1:0] s_addr  [`RIB_N_SLAVES];
    wire  [`RIB_DATA_W-1:0] s_wdata [`RIB_N_SLAVES];
    wire  [`RIB_DATA_W-1:0] s_rdata [`RIB_N_SLAVES];
    wire                    s_we    [`RIB_N_SLAVES];
    wire                    s_req   [`RIB_N_SLAVES];
    wire                    s_ack   [`RIB_N_SLAVES];
    wire                    hold_flag;

    logic [`RIB_DATA_W-1:0] ref_mem [`RIB_N_SLAVES][16];
    int                     exp_grant;
    int                     cycle_cnt = 0;
    int                     value_errs = 0;
    int                     other_errs = 0;
    integer                 seed = 32'h2559;

    rib_top dut (
        .clk (clk), .arst_n_i (arst_n_i), .hold_flag_o (hold_flag),
        .m0_addr_i (m_addr[0]), .m0_data_i (m_wdata[0]), .m0_data_o (m_rdata[0]),
        .m0_req_i (m_req[0]), .m0_we_i (m_we[0]), .m0_ack_o (m_ack[0]),
        .m1_addr_i (m_addr[1]), .m1_data_i (m_wdata[1]), .m1_data_o (m_rdata[1]),
        .m1_req_i (m_req[1]), .m1_we_i (m_we[1]), .m1_ack_o (m_ack[1]),
        .m2_addr_i (m_addr[2]), .m2_data_i (m_wdata[2]), .m2_data_o (m_rdata[2]),
        .m2_req_i (m_req[2]), .m2_we_i (m_we[2]), .m2_ack_o (m_ack[2]),
        .s0_addr_o (s_addr[0]), .s0_data_o (s_wdata[0]), .s0_data_i (s_rdata[0]),
        .s0_req_o (s_req[0]), .s0_we_o (s_we[0]), .s0_ack_i (s_ack[0]),
        .s1_addr_o (s_addr[1]), .s1_data_o (s_wdata[1]), .s1_data_i (s_rdata[1]),
        .s1_req_o (s_req[1]), .s1_we_o (s_we[1]), .s1_ack_i (s_ack[1]),
        .s2_addr_o (s_addr[2]), .s2_data_o (s_wdata[2]), .s2_data_i (s_rdata[2]),
        .s2_req_o (s_req[2]), .s2_we_o (s_we[2]), .s2_ack_i (s_ack[2]),
        .s3_addr_o (s_addr[3]), .s3_data_o (s_wdata[3]), .s3_data_i (s_rdata[3]),
        .s3_req_o (s_req[3]), .s3_we_o (s_we[3]), .s3_ack_i (s_ack[3])
    );

    for (genvar i = 0; i < `RIB_N_SLAVES; i++) begin : g_slave
        rib_slave_model #(.SLAVE_ID(i)) u_slave (
            .clk    (clk),
            .addr_i (s_addr[i]),
            .data_i (s_wdata[i]),
            .we_i   (s_we[i]),
            .req_i  (s_req[i]),
            .data_o (s_rdata[i]),
            .ack_o  (s_ack[i])
        );
    end

    // m0 over m2 over fetch
    function automatic int grant_by_priority(input logic [2:0] req);
        if (req[0]) begin
            return 0;
        end else if (req[2]) begin
            return 2;
        end
        return 1;
    endfunction

    function automatic int slave_select(input logic [`RIB_ADDR_W-1:0] addr);
        return int'(addr[31:28]);
    endfunction

    function automatic logic [`RIB_ADDR_W-1:0] slave_offset(input logic [`RIB_ADDR_W-1:0] addr);
        return {4'h0, addr[27:0]};
    endfunction

    function automatic logic [`RIB_DATA_W-1:0] fill_word(input int s, input int i);
        return 32'hC0DE_0000 | (s << 8) | i;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
        value_errs++;
    endtask

    task automatic check_cycle();
        int                     sel;
        int                     gm;
        logic                   exp_ack;
        logic                   exp_req;
        logic                   exp_we;
        logic [`RIB_DATA_W-1:0] exp_data;
        logic [`RIB_ADDR_W-1:0] off;
        if (hold_flag !== (m_req[0] | m_req[2])) begin
            report_mismatch("hold_flag_o", m_req[0] | m_req[2], hold_flag);
        end
        for (int m = 0; m < `RIB_N_MASTERS; m++) begin
            sel      = slave_select(m_addr[m]);
            off      = slave_offset(m_addr[m]);
            exp_ack  = (exp_grant == m) && m_req[m] && (sel < `RIB_N_SLAVES);
            exp_data = (m == 1) ? `RIB_INST_NOP : '0;
            if (exp_ack) begin
                exp_data = ref_mem[sel][off[5:2]];
            end
            if (m_ack[m] !== exp_ack) begin
                report_mismatch($sformatf("m%0d_ack_o", m), exp_ack, m_ack[m]);
            end
            if (m_rdata[m] !== exp_data) begin
                report_mismatch($sformatf("m%0d_data_o", m), exp_data, m_rdata[m]);
            end
        end
        gm  = exp_grant;
        sel = slave_select(m_addr[gm]);
        off = slave_offset(m_addr[gm]);
        for (int s = 0; s < `RIB_N_SLAVES; s++) begin
            exp_req = m_req[gm] && (sel == s);
            exp_we  = exp_req && m_we[gm];
            if (s_req[s] !== exp_req) begin
                report_mismatch($sformatf("s%0d_req_o", s), exp_req, s_req[s]);
            end
            if (s_we[s] !== exp_we) begin
                report_mismatch($sformatf("s%0d_we_o", s), exp_we, s_we[s]);
            end
            if (exp_req && s_addr[s] !== off) begin
                report_mismatch($sformatf("s%0d_addr_o", s), off, s_addr[s]);
            end
            if (exp_req && s_wdata[s] !== m_wdata[gm]) begin
                report_mismatch($sformatf("s%0d_data_o", s), m_wdata[gm], s_wdata[s]);
            end
        end
        // slave stores this at the coming edge
        if (m_req[gm] && m_we[gm] && sel < `RIB_N_SLAVES) begin
            ref_mem[sel][off[5:2]] = m_wdata[gm];
        end
    endtask

    task automatic bus_access(input int m, input logic [31:0] addr, input logic we,
                              input logic [31:0] wdata, input bit expect_ack,
                              input int max_wait, output int ack_cycle);
        int waited;
        waited    = 0;
        ack_cycle = -1;
        @(posedge clk);
        #1;
        m_addr[m]  = addr;
        m_wdata[m] = wdata;
        m_we[m]    = we;
        m_req[m]   = 1'b1;
        #2;
        while (m_ack[m] !== 1'b1 && waited < max_wait) begin
            @(posedge clk);
            #3;
            waited++;
        end
        if (m_ack[m] === 1'b1) begin
            ack_cycle = cycle_cnt;
            if (!expect_ack) begin
                $display("m%0d was acked for unmapped address %h at %0t", m, addr, $time);
                other_errs++;
            end
        end else if (expect_ack) begin
            $display("timeout: m%0d got no ack for %h within %0d cycles", m, addr, max_wait);
            other_errs++;
        end
        @(posedge clk);
        #1;
        m_req[m] = 1'b0;                    // withdraw after ack or give up
        m_we[m]  = 1'b0;
    endtask

    task automatic random_traffic(input int m);
        logic [31:0] addr;
        logic [31:0] r;
        int          c;
        for (int n = 0; n < RAND_OPS; n++) begin
            addr       = $random(seed);
            addr[31:30] = 2'b00;            // selects 0..3 only
            addr[1:0]  = 2'b00;
            r          = $random(seed);
            repeat (r[1:0]) @(posedge clk);
            bus_access(m, addr, r[4], $random(seed), 1'b1, ACCESS_TIMEOUT, c);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    always @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            exp_grant <= 1;
        end else begin
            exp_grant <= grant_by_priority({m_req[2], m_req[1], m_req[0]});
        end
    end

    // runs through reset too
    always @(posedge clk) begin
        #3;
        check_cycle();
    end

    initial begin
        int c0;
        int c1;
        int c2;
        logic [31:0] addr;
        $timeformat(-9, 0, " ns", 0);
        arst_n_i = 1'b0;
        for (int m = 0; m < `RIB_N_MASTERS; m++) begin
            m_addr[m]  = '0;
            m_wdata[m] = '0;
            m_we[m]    = 1'b0;
            m_req[m]   = 1'b0;
        end
        for (int s = 0; s < `RIB_N_SLAVES; s++) begin
            for (int i = 0; i < 16; i++) begin
                ref_mem[s][i] = fill_word(s, i);
            end
        end
        repeat (10) @(posedge clk);
        #1;
        arst_n_i = 1'b1;

        // fetch sees the NOP on an idle bus
        @(posedge clk);
        #3;
        if (m_rdata[1] !== `RIB_INST_NOP) begin
            report_mismatch("m1_data_o", `RIB_INST_NOP, m_rdata[1]);
        end

        // fetch starts a cycle late so the parked grant cannot serve it first
        fork
            bus_access(0, 32'h0000_0010, 1'b0, '0, 1'b1, ACCESS_TIMEOUT, c0);
            bus_access(2, 32'h2000_0020, 1'b0, '0, 1'b1, ACCESS_TIMEOUT, c2);
            begin
                @(posedge clk);
                bus_access(1, 32'h1000_0030, 1'b0, '0, 1'b1, ACCESS_TIMEOUT, c1);
            end
        join
        if (!(c0 < c2 && c2 < c1)) begin
            $display("ack order wrong: m0 at %0d, m2 at %0d, m1 at %0d", c0, c2, c1);
            other_errs++;
        end

        for (int s = 0; s < `RIB_N_SLAVES; s++) begin
            addr = {4'(s), 22'h2A_5A5A, 4'(s + 5), 2'b00};
            bus_access(0, addr, 1'b1, 32'hD0C0_0000 + s, 1'b1, ACCESS_TIMEOUT, c0);
        end
        for (int s = 0; s < `RIB_N_SLAVES; s++) begin
            addr = {4'(s), 22'h2A_5A5A, 4'(s + 5), 2'b00};
            bus_access(s % 3, addr, 1'b0, '0, 1'b1, ACCESS_TIMEOUT, c0);
        end

        bus_access(2, 32'h4000_0004, 1'b0, '0, 1'b0, 8, c2);
        bus_access(2, 32'hB123_4568, 1'b1, 32'h1234_5678, 1'b0, 8, c2);
        bus_access(0, 32'hF000_0000, 1'b0, '0, 1'b0, 8, c0);

        fork
            random_traffic(0);
            random_traffic(1);
            random_traffic(2);
        join

        repeat (4) @(posedge clk);
        $display("value errors: %0d, other errors: %0d", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule
